//--- project.f
spim_pkg.sv
spim_cmd_stage.sv
spim_word_seq.sv
spim_shifter.sv
spim_pad_ctrl.sv
spim_top.sv
tb_clk_gen.sv
tb_spim.sv

//--- spim_cmd_stage.sv
// command entry over a four-phase req/ack handshake, holds one pending command for the sequencer
`timescale 1ns/100ps
`default_nettype none

module spim_cmd_stage (
  input  logic                clk_i,
  input  logic                rstn_i,
  input  logic                cmd_req_i,
  input  spim_pkg::spim_cmd_t cmd_i,
  output logic                cmd_ack_o,
  output logic                cmd_valid_o,
  output spim_pkg::spim_cmd_t cmd_o,
  input  logic                cmd_ready_i
);

  typedef enum logic {
    S_WAIT,
    S_ACK
  } state_e;

  state_e              r_state;
  state_e              state_next;
  logic                r_valid;
  spim_pkg::spim_cmd_t r_cmd;
  logic                take;

  // capture only while the slot is empty
  assign take = (r_state == S_WAIT) && cmd_req_i && !r_valid;

  always_comb
  begin
    state_next = r_state;
    case (r_state)
      S_WAIT:
        if (take)
          state_next = S_ACK;
      S_ACK:
        // hold ack until the host lets go of req
        if (!cmd_req_i)
          state_next = S_WAIT;
      default:
        state_next = S_WAIT;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      r_state <= S_WAIT;
      r_valid <= 1'b0;
    end
    else
    begin
      r_state <= state_next;
      if (take)
        r_valid <= 1'b1;
      else if (cmd_ready_i)
        r_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
      r_cmd <= cmd_i;
  end

  assign cmd_ack_o   = (r_state == S_ACK);
  assign cmd_valid_o = r_valid;
  assign cmd_o       = r_cmd;

  // host keeps the command steady until it is acknowledged
  a_cmd_stable : assert property (@(posedge clk_i) disable iff (!rstn_i)
    (cmd_req_i && !cmd_ack_o) ##1 cmd_req_i |-> $stable(cmd_i));

endmodule

`default_nettype wire

//--- spim_pad_ctrl.sv
// pad control, decodes the mode into output enables and registers every pin toward the pads
`timescale 1ns/100ps
`default_nettype none

module spim_pad_ctrl (
  input  logic                 clk_i,
  input  logic                 rstn_i,
  input  spim_pkg::spim_pad_t  pad_i,
  input  spim_pkg::spim_mode_e mode_i,
  output logic                 spi_sclk_o,
  output logic [3:0]           spi_sdo_o,
  output logic [3:0]           spi_oen_o
);

  logic [3:0]          mode_oen;
  spim_pkg::spim_pad_t r_pad;

  //////////////////////////////////////////////////////////////////////
  // enable decode
  //////////////////////////////////////////////////////////////////////

  // only the transmit modes drive any line
  always_comb
  begin
    case (mode_i)
      spim_pkg::MODE_STD_TX:
        mode_oen = 4'b1110;
      spim_pkg::MODE_QUAD_TX:
        mode_oen = 4'b0000;
      default:
        mode_oen = 4'b1111;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      r_pad.sclk <= 1'b0;
      r_pad.sdo  <= 4'h0;
      r_pad.oen  <= 4'hf;
    end
    else
    begin
      r_pad.sclk <= pad_i.sclk;
      // undriven lines rest at zero
      r_pad.sdo  <= pad_i.sdo & ~mode_oen;
      r_pad.oen  <= mode_oen;
    end
  end

  assign spi_sclk_o = r_pad.sclk;
  assign spi_sdo_o  = r_pad.sdo;
  assign spi_oen_o  = r_pad.oen;

endmodule

`default_nettype wire

//--- spim_pkg.sv
// shared widths, pad mode codes and packed structs for the SPI master and its testbench
`default_nettype none

package spim_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // data word and word count
  localparam int DATA_W = 32;
  localparam int CNT_W  = 16;

  // bits-per-word field holds bits minus one, so 5 bits reach 32
  localparam int BITS_W = 5;

  //////////////////////////////////////////////////////////////////////
  // pad mode
  //////////////////////////////////////////////////////////////////////

  // idle and both receive modes leave every line undriven
  typedef enum logic [2:0] {
    MODE_IDLE    = 3'd0,
    MODE_STD_TX  = 3'd1,
    MODE_STD_RX  = 3'd2,
    MODE_QUAD_TX = 3'd3,
    MODE_QUAD_RX = 3'd4
  } spim_mode_e;

  //////////////////////////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////////////////////////

  // one command as seen by the host
  typedef struct packed {
    logic              is_rx;
    logic              quad;
    logic              lsb_first;
    logic              cpol;
    logic [BITS_W-1:0] bits_m1;
    logic [CNT_W-1:0]  words_m1;
  } spim_cmd_t;

  // one word on its way from the sequencer to the shifter
  // data is zero for receive commands
  typedef struct packed {
    logic [DATA_W-1:0] data;
    spim_cmd_t         cmd;
    logic              last;
  } spim_beat_t;

  // pad side view before the output registers, oen is active low
  typedef struct packed {
    logic       sclk;
    logic [3:0] sdo;
    logic [3:0] oen;
  } spim_pad_t;

endpackage

`default_nettype wire

//--- spim_shifter.sv
// serial shifter, moves one word per beat sequence on one or four lines and makes the serial clock
`timescale 1ns/100ps
`default_nettype none

module spim_shifter #(
  parameter int DATA_W = 32,
  parameter int CNT_W  = 16
) (
  input  logic                 clk_i,
  input  logic                 rstn_i,
  input  logic                 beat_valid_i,
  input  spim_pkg::spim_beat_t beat_i,
  output logic                 beat_ready_o,
  input  logic [3:0]           spi_sdi_i,
  output logic [DATA_W-1:0]    rx_data_o,
  output logic                 rx_valid_o,
  input  logic                 rx_ready_i,
  output spim_pkg::spim_pad_t  pad_o,
  output spim_pkg::spim_mode_e mode_o,
  output logic                 done_o
);

  localparam int IDX_W = $clog2(DATA_W);

  // control state
  logic                r_active;
  logic                r_phase;
  logic                r_in_cmd;
  logic                r_cpol;
  logic                r_rx_valid;
  logic                r_done;
  logic [CNT_W-1:0]    r_word_cnt;
  // current word
  spim_pkg::spim_cmd_t r_cmd;
  logic                r_last;
  logic [DATA_W-1:0]   r_data;
  logic [DATA_W-1:0]   r_rx_data;
  logic [IDX_W-1:0]    r_idx;

  logic [IDX_W-1:0]    step_m1;
  logic [IDX_W-1:0]    bits_m1;
  logic                beat_end;
  logic                word_end;
  logic                rx_free;
  logic                start;
  logic [3:0]          sdo;
  logic [DATA_W-1:0]   rx_word;

  //////////////////////////////////////////////////////////////////////
  // beat control
  //////////////////////////////////////////////////////////////////////

  assign step_m1  = r_cmd.quad ? IDX_W'(3) : '0;
  assign bits_m1  = IDX_W'(r_cmd.bits_m1);
  assign beat_end = r_active && r_phase;
  assign word_end = beat_end &&
                    (r_cmd.lsb_first ? (r_idx + step_m1 == bits_m1) : (r_idx == step_m1));

  // a finishing RX word fills the output register, so no word starts behind it
  assign rx_free      = !r_rx_valid || rx_ready_i;
  assign beat_ready_o = rx_free && (!r_active || (word_end && !r_cmd.is_rx));
  assign start        = beat_valid_i && beat_ready_o;

  // lane mapping, r_idx points at the bit on sdo[3] (msb first) or sdo[0] (lsb first)
  always_comb
  begin
    sdo     = '0;
    rx_word = r_data;
    if (r_cmd.quad)
    begin
      for (int k = 0; k < 4; k++)
      begin
        if (r_cmd.lsb_first)
        begin
          sdo[k]                     = r_data[r_idx + IDX_W'(k)];
          rx_word[r_idx + IDX_W'(k)] = spi_sdi_i[k];
        end
        else
        begin
          sdo[k]                         = r_data[r_idx - IDX_W'(3 - k)];
          rx_word[r_idx - IDX_W'(3 - k)] = spi_sdi_i[k];
        end
      end
    end
    else
    begin
      sdo[0]         = r_data[r_idx];
      rx_word[r_idx] = spi_sdi_i[1];
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      r_active   <= 1'b0;
      r_phase    <= 1'b0;
      r_in_cmd   <= 1'b0;
      r_cpol     <= 1'b0;
      r_rx_valid <= 1'b0;
      r_done     <= 1'b0;
      r_word_cnt <= '0;
    end
    else
    begin
      r_done <= word_end && r_last;
      if (start)
      begin
        r_active <= 1'b1;
        r_phase  <= 1'b0;
        r_in_cmd <= 1'b1;
        r_cpol   <= beat_i.cmd.cpol;
      end
      else if (r_active)
      begin
        r_phase <= !r_phase;
        if (word_end)
        begin
          r_active <= 1'b0;
          if (r_last)
            r_in_cmd <= 1'b0;
        end
      end

      if (word_end)
        r_word_cnt <= r_last ? '0 : r_word_cnt + 1'b1;

      if (word_end && r_cmd.is_rx)
        r_rx_valid <= 1'b1;
      else if (rx_ready_i)
        r_rx_valid <= 1'b0;
    end
  end

  // sdi is taken at the end of the active half of each beat
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      r_cmd  <= beat_i.cmd;
      r_last <= beat_i.last;
      r_data <= beat_i.data[DATA_W-1:0];
      r_idx  <= beat_i.cmd.lsb_first ? '0 : IDX_W'(beat_i.cmd.bits_m1);
    end
    else if (beat_end)
    begin
      if (r_cmd.is_rx)
        r_data <= rx_word;
      r_idx <= r_cmd.lsb_first ? r_idx + step_m1 + 1'b1 : r_idx - step_m1 - 1'b1;
    end
    if (word_end && r_cmd.is_rx)
      r_rx_data <= rx_word;
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  // second half of a beat sits at the active level
  assign pad_o.sclk = r_cpol ^ beat_end;
  assign pad_o.sdo  = sdo;
  assign pad_o.oen  = (r_in_cmd && !r_cmd.is_rx) ? (r_cmd.quad ? 4'b0000 : 4'b1110) : 4'b1111;

  always_comb
  begin
    if (!r_in_cmd)
      mode_o = spim_pkg::MODE_IDLE;
    else if (r_cmd.quad)
      mode_o = r_cmd.is_rx ? spim_pkg::MODE_QUAD_RX : spim_pkg::MODE_QUAD_TX;
    else
      mode_o = r_cmd.is_rx ? spim_pkg::MODE_STD_RX : spim_pkg::MODE_STD_TX;
  end

  assign rx_data_o  = r_rx_data;
  assign rx_valid_o = r_rx_valid;
  assign done_o     = r_done;

  a_rx_hold : assert property (@(posedge clk_i) disable iff (!rstn_i)
    rx_valid_o && !rx_ready_i |=> rx_valid_o && $stable(rx_data_o));

  // the sequencer marks the last word exactly words_m1+1 words in
  a_last_word : assert property (@(posedge clk_i) disable iff (!rstn_i)
    word_end && r_last |-> (r_word_cnt == CNT_W'(r_cmd.words_m1)));

endmodule

`default_nettype wire

//--- spim_top.sv
// SPI master top level, chains command stage, word sequencer, shifter and pad control
`timescale 1ns/100ps
`default_nettype none

module spim_top #(
  parameter int DATA_W = spim_pkg::DATA_W,
  parameter int CNT_W  = spim_pkg::CNT_W
) (
  input  logic                clk_i,
  input  logic                rstn_i,
  // command entry
  input  logic                cmd_req_i,
  input  spim_pkg::spim_cmd_t cmd_i,
  output logic                cmd_ack_o,
  // data streams
  input  logic [DATA_W-1:0]   tx_data_i,
  input  logic                tx_valid_i,
  output logic                tx_ready_o,
  output logic [DATA_W-1:0]   rx_data_o,
  output logic                rx_valid_o,
  input  logic                rx_ready_i,
  // pins
  output logic                spi_sclk_o,
  output logic [3:0]          spi_sdo_o,
  output logic [3:0]          spi_oen_o,
  input  logic [3:0]          spi_sdi_i,
  output logic                done_o
);

  logic                 cmd_valid;
  spim_pkg::spim_cmd_t  cmd;
  logic                 cmd_ready;
  logic                 beat_valid;
  spim_pkg::spim_beat_t beat;
  logic                 beat_ready;
  spim_pkg::spim_pad_t  pad;
  spim_pkg::spim_mode_e mode;

  spim_cmd_stage i_cmd_stage (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .cmd_req_i   (cmd_req_i),
    .cmd_i       (cmd_i),
    .cmd_ack_o   (cmd_ack_o),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd),
    .cmd_ready_i (cmd_ready)
  );

  spim_word_seq #(.DATA_W(DATA_W), .CNT_W(CNT_W)) i_word_seq (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .cmd_ready_o  (cmd_ready),
    .tx_data_i    (tx_data_i),
    .tx_valid_i   (tx_valid_i),
    .tx_ready_o   (tx_ready_o),
    .beat_valid_o (beat_valid),
    .beat_o       (beat),
    .beat_ready_i (beat_ready)
  );

  spim_shifter #(.DATA_W(DATA_W), .CNT_W(CNT_W)) i_shifter (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .beat_valid_i (beat_valid),
    .beat_i       (beat),
    .beat_ready_o (beat_ready),
    .spi_sdi_i    (spi_sdi_i),
    .rx_data_o    (rx_data_o),
    .rx_valid_o   (rx_valid_o),
    .rx_ready_i   (rx_ready_i),
    .pad_o        (pad),
    .mode_o       (mode),
    .done_o       (done_o)
  );

  spim_pad_ctrl i_pad_ctrl (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .pad_i      (pad),
    .mode_i     (mode),
    .spi_sclk_o (spi_sclk_o),
    .spi_sdo_o  (spi_sdo_o),
    .spi_oen_o  (spi_oen_o)
  );

endmodule

`default_nettype wire

//--- spim_word_seq.sv
// word sequencer, counts the words of a command and hands each one with its TX data to the shifter
`timescale 1ns/100ps
`default_nettype none

module spim_word_seq #(
  parameter int DATA_W = 32,
  parameter int CNT_W  = 16
) (
  input  logic                 clk_i,
  input  logic                 rstn_i,
  input  logic                 cmd_valid_i,
  input  spim_pkg::spim_cmd_t  cmd_i,
  output logic                 cmd_ready_o,
  input  logic [DATA_W-1:0]    tx_data_i,
  input  logic                 tx_valid_i,
  output logic                 tx_ready_o,
  output logic                 beat_valid_o,
  output spim_pkg::spim_beat_t beat_o,
  input  logic                 beat_ready_i
);

  localparam int BEAT_DATA_W = spim_pkg::DATA_W;

  logic                 r_busy;
  logic [CNT_W-1:0]     r_cnt;
  spim_pkg::spim_cmd_t  r_cmd;
  logic                 r_beat_valid;
  spim_pkg::spim_beat_t r_beat;
  logic                 cmd_take;
  logic                 slot_free;
  logic                 load;

  //////////////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////////////

  assign cmd_ready_o = !r_busy;
  assign cmd_take    = cmd_valid_i && cmd_ready_o;

  // the output slot frees up in the same cycle the shifter takes it,
  // which lets the next word be fetched while the shifter still runs
  assign slot_free = !r_beat_valid || beat_ready_i;

  // receive words need no TX data
  assign tx_ready_o = r_busy && !r_cmd.is_rx && slot_free;
  assign load       = r_busy && slot_free && (r_cmd.is_rx || tx_valid_i);

  //////////////////////////////////////////////////////////////////////
  // word counter and output slot
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      r_busy       <= 1'b0;
      r_cnt        <= '0;
      r_beat_valid <= 1'b0;
    end
    else
    begin
      if (cmd_take)
      begin
        r_busy <= 1'b1;
        r_cnt  <= CNT_W'(cmd_i.words_m1);
      end
      else if (load)
      begin
        if (r_cnt == '0)
          r_busy <= 1'b0;
        else
          r_cnt <= r_cnt - 1'b1;
      end

      if (load)
        r_beat_valid <= 1'b1;
      else if (beat_ready_i)
        r_beat_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_take)
      r_cmd <= cmd_i;
    if (load)
    begin
      r_beat.data <= r_cmd.is_rx ? '0 : BEAT_DATA_W'(tx_data_i);
      r_beat.cmd  <= r_cmd;
      r_beat.last <= (r_cnt == '0);
    end
  end

  assign beat_valid_o = r_beat_valid;
  assign beat_o       = r_beat;

  // quad words move four bits per beat, so the word length must fit
  a_quad_bits : assert property (@(posedge clk_i) disable iff (!rstn_i)
    cmd_take && cmd_i.quad |-> (cmd_i.bits_m1[1:0] == 2'b11));

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// testbench clock and reset source, drives a 4 ns clock and holds reset low for the first cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rstn_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release reset just after a rising edge, like every other input
  initial
  begin
    rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rstn_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_spim.sv
// testbench for the SPI master, runs a command table against a slave model and checks every word
`timescale 1ns/100ps
`default_nettype none

module tb_spim;

  localparam int NROWS = 12;

  // TX data for transmit rows, slave data for receive rows
  typedef struct packed {
    spim_pkg::spim_cmd_t cmd;
    logic                gaps;
    logic [3:0][31:0]    words;
  } row_t;

  logic                        clk;
  logic                        rstn;
  logic                        cmd_req;
  spim_pkg::spim_cmd_t         cmd;
  logic                        cmd_ack;
  logic [spim_pkg::DATA_W-1:0] tx_data;
  logic                        tx_valid;
  logic                        tx_ready;
  logic [spim_pkg::DATA_W-1:0] rx_data;
  logic                        rx_valid;
  logic                        rx_ready;
  logic                        spi_sclk;
  logic [3:0]                  spi_sdo;
  logic [3:0]                  spi_oen;
  logic [3:0]                  spi_sdi;
  logic                        done;

  row_t             rows [NROWS];
  logic [3:0][31:0] cap [NROWS];
  int               limit = 0;
  int               cycles = 0;
  int               done_cnt = 0;
  logic             prev_done = 1'b0;
  logic             prev_sclk = 1'b0;
  int               srow = 0;
  int               sbeat = 0;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rstn_o(rstn));

  spim_top #(.DATA_W(spim_pkg::DATA_W), .CNT_W(spim_pkg::CNT_W)) i_dut (
    .clk_i (clk), .rstn_i (rstn),
    .cmd_req_i (cmd_req), .cmd_i (cmd), .cmd_ack_o (cmd_ack),
    .tx_data_i (tx_data), .tx_valid_i (tx_valid), .tx_ready_o (tx_ready),
    .rx_data_o (rx_data), .rx_valid_o (rx_valid), .rx_ready_i (rx_ready),
    .spi_sclk_o (spi_sclk), .spi_sdo_o (spi_sdo), .spi_oen_o (spi_oen),
    .spi_sdi_i (spi_sdi), .done_o (done)
  );

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////

  function automatic row_t make_row(input logic is_rx, input logic quad, input logic lsb,
                                    input logic cpol, input int nbits, input int nwords,
                                    input logic gaps, input logic [127:0] words);
    row_t row;
    row.cmd.is_rx     = is_rx;
    row.cmd.quad      = quad;
    row.cmd.lsb_first = lsb;
    row.cmd.cpol      = cpol;
    row.cmd.bits_m1   = 5'(nbits - 1);
    row.cmd.words_m1  = 16'(nwords - 1);
    row.gaps          = gaps;
    row.words         = words;
    return row;
  endfunction

  // word bit carried on line k during beat b of a word
  function automatic int bit_index(input spim_pkg::spim_cmd_t c, input int b, input int k);
    int nbits;
    nbits = int'(c.bits_m1) + 1;
    if (!c.quad)
      return c.lsb_first ? b : nbits - 1 - b;
    return c.lsb_first ? 4 * b + k : nbits - 4 - 4 * b + k;
  endfunction

  function automatic int beats_per_word(input spim_pkg::spim_cmd_t c);
    return c.quad ? (int'(c.bits_m1) + 1) / 4 : int'(c.bits_m1) + 1;
  endfunction

  function automatic logic [31:0] low_bits(input logic [31:0] word, input int nbits);
    logic [63:0] mask;
    mask = (64'd1 << nbits) - 64'd1;
    return word & mask[31:0];
  endfunction

  function automatic logic [3:0] oen_for(input spim_pkg::spim_cmd_t c);
    if (c.is_rx)
      return 4'hf;
    return c.quad ? 4'h0 : 4'he;
  endfunction

  // standard receive uses line 1, quad uses all four
  function automatic logic [3:0] sdi_bits(input int r, input int n);
    spim_pkg::spim_cmd_t c;
    int                  bpw;
    logic [3:0]          v;
    c   = rows[r].cmd;
    bpw = beats_per_word(c);
    v   = '0;
    for (int k = 0; k < (c.quad ? 4 : 1); k++)
      v[c.quad ? k : 1] = rows[r].words[n / bpw][bit_index(c, n % bpw, k)];
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks and host tasks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      fail_stop($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic next_slot();
    @(posedge clk);
    #1;
  endtask

  task automatic issue_cmds();
    int r;
    for (r = 0; r < NROWS; r++)
    begin
      next_slot();
      cmd     = rows[r].cmd;
      cmd_req = 1'b1;
      do
        @(negedge clk);
      while (!cmd_ack);
      // the command before this one is still running
      if (r > 0)
        check("done_o count at cmd_ack_o", done_cnt >= r, 1'b0);
      next_slot();
      cmd_req = 1'b0;
      @(negedge clk);
      check("cmd_ack_o", cmd_ack, 1'b1);
      @(negedge clk);
      check("cmd_ack_o", cmd_ack, 1'b0);
    end
  endtask

  task automatic feed_tx();
    int r;
    int w;
    next_slot();
    for (r = 0; r < NROWS; r++)
    begin
      for (w = 0; w <= int'(rows[r].cmd.words_m1) && !rows[r].cmd.is_rx; w++)
      begin
        repeat (rows[r].gaps ? int'($urandom % 4) : 0) next_slot();
        tx_data  = rows[r].words[w];
        tx_valid = 1'b1;
        do
          @(negedge clk);
        while (!tx_ready);
        next_slot();
        tx_valid = 1'b0;
      end
    end
  endtask

  task automatic drain_rx();
    int   r;
    int   w;
    logic hit;
    next_slot();
    for (r = 0; r < NROWS; r++)
    begin
      for (w = 0; w <= int'(rows[r].cmd.words_m1) && rows[r].cmd.is_rx; w++)
      begin
        hit = 1'b0;
        while (!hit)
        begin
          rx_ready = rows[r].gaps ? ($urandom % 3 != 0) : 1'b1;
          @(negedge clk);
          hit = rx_valid && rx_ready;
          if (hit)
            check("rx_data_o", rx_data,
                  low_bits(rows[r].words[w], int'(rows[r].cmd.bits_m1) + 1));
          next_slot();
        end
      end
    end
    rx_ready = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // slave model, done counter and timeout
  //////////////////////////////////////////////////////////////////////

  // capture on leading edges, present the next bits after trailing edges
  always @(posedge clk)
  begin : slave
    spim_pkg::spim_cmd_t c;
    int                  bpw;
    int                  k;
    #1;
    if (rstn && srow < NROWS && spi_sclk != prev_sclk)
    begin
      c   = rows[srow].cmd;
      bpw = beats_per_word(c);
      if (spi_sclk != c.cpol)
      begin
        check("spi_oen_o", spi_oen, oen_for(c));
        for (k = 0; k < (c.quad ? 4 : 1) && !c.is_rx; k++)
          cap[srow][sbeat / bpw][bit_index(c, sbeat % bpw, k)] = spi_sdo[k];
        sbeat++;
      end
      else
      begin
        if (sbeat == bpw * (int'(c.words_m1) + 1))
        begin
          srow++;
          sbeat = 0;
        end
        if (srow < NROWS)
          spi_sdi = sdi_bits(srow, sbeat);
      end
    end
    prev_sclk = spi_sclk;
  end

  always @(negedge clk)
  begin
    if (rstn)
    begin
      cycles = cycles + 1;
      if (cycles > limit)
        fail_stop($sformatf("timeout after %0d cycles, the commands did not finish", cycles));
      if (done && prev_done)
        fail_stop("done_o stayed high for more than one cycle");
      if (done && !prev_done)
        done_cnt <= done_cnt + 1;
    end
    prev_done = done;
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int r;
    int w;
    int total_bits;
    void'($urandom(32'hfcb8));
    // is_rx quad lsb cpol bits words gaps, words listed from index 3 down to 0
    rows[0]  = make_row(0, 0, 0, 0,  8, 3, 0, {32'h0, 32'h5a, 32'hc3, 32'h81});
    rows[1]  = make_row(0, 0, 0, 0, 32, 2, 0, {64'h0, 32'h12345678, 32'hdeadbeef});
    rows[2]  = make_row(0, 1, 0, 0, 16, 2, 0, {64'h0, 32'h0f1e, 32'ha5c3});
    rows[3]  = make_row(0, 1, 1, 0, 16, 2, 0, {64'h0, 32'hfedc, 32'h1234});
    rows[4]  = make_row(1, 0, 0, 0, 12, 2, 0, {64'h0, 32'h5e1, 32'habc});
    rows[5]  = make_row(1, 0, 1, 0,  8, 2, 0, {64'h0, 32'h3c, 32'h96});
    rows[6]  = make_row(1, 1, 0, 0, 32, 1, 0, {96'h0, 32'hcafef00d});
    rows[7]  = make_row(1, 1, 1, 0, 16, 2, 0, {64'h0, 32'h7bde, 32'h8421});
    // polarity 1 with random gaps on both streams
    rows[8]  = make_row(0, 0, 1, 1, 32, 4, 1,
                        {32'hffff0001, 32'h2468ace0, 32'h13579bdf, 32'h0badf00d});
    rows[9]  = make_row(1, 1, 0, 1, 20, 3, 1, {32'h0, 32'hfedcb, 32'h12345, 32'h9abcd});
    rows[10] = make_row(0, 1, 1, 1,  8, 4, 1, {32'h99, 32'h66, 32'h18, 32'he7});
    rows[11] = make_row(1, 0, 1, 1, 24, 4, 1,
                        {32'h5f5f5f, 32'h800000, 32'h000001, 32'ha1b2c3});
    total_bits = 0;
    for (r = 0; r < NROWS; r++)
    begin
      cap[r]     = '0;
      total_bits += (int'(rows[r].cmd.bits_m1) + 1) * (int'(rows[r].cmd.words_m1) + 1);
    end
    limit    = 40 * total_bits + 200;
    cmd_req  = 1'b0;
    cmd      = '0;
    tx_data  = '0;
    tx_valid = 1'b0;
    rx_ready = 1'b0;
    spi_sdi  = '0;

    wait (rstn);
    @(negedge clk);
    check("spi_oen_o", spi_oen, 4'hf);
    check("spi_sdo_o", spi_sdo, 4'h0);
    check("spi_sclk_o", spi_sclk, 1'b0);
    check("done_o", done, 1'b0);
    check("cmd_ack_o", cmd_ack, 1'b0);
    check("tx_ready_o", tx_ready, 1'b0);
    check("rx_valid_o", rx_valid, 1'b0);

    fork
      issue_cmds();
      feed_tx();
      drain_rx();
    join
    wait (done_cnt == NROWS);
    repeat (4) @(negedge clk);

    check("slave command count", srow, NROWS);
    check("done_o pulse count", done_cnt, NROWS);
    // last command runs with polarity 1
    check("spi_sclk_o", spi_sclk, 1'b1);
    check("spi_oen_o", spi_oen, 4'hf);
    for (r = 0; r < NROWS; r++)
    begin
      for (w = 0; w <= int'(rows[r].cmd.words_m1) && !rows[r].cmd.is_rx; w++)
        check($sformatf("spi_sdo_o word %0d of command %0d", w, r), cap[r][w],
              low_bits(rows[r].words[w], int'(rows[r].cmd.bits_m1) + 1));
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
